// ==== Bender.yml ====
package:
  name: ntt_addr_gen

sources:
  - hdl/ntt_addr_pkg.sv
  - hdl/ntt_step_if.sv
  - hdl/delay_line.sv
  - hdl/ntt_sequencer.sv
  - hdl/ntt_read_addr.sv
  - hdl/ntt_twiddle_addr.sv
  - hdl/ntt_write_addr.sv
  - hdl/ntt_addr_gen.sv
  - target: simulation
    files:
      - dv/ntt_addr_checker.sv
      - dv/ntt_addr_gen_tb.sv

// ==== dv/ntt_addr_checker.sv ====
// checker for the NTT address generator, per-cycle compare, per-test lines and totals
`timescale 1ns/1ps

module ntt_addr_checker (
    input logic                    clk,
    input logic                    check_en,
    // dut ports
    input ntt_addr_pkg::mem_addr_t raddr0,
    input ntt_addr_pkg::tw_addr_t  raddr_tw,
    input ntt_addr_pkg::mem_addr_t waddr0,
    input ntt_addr_pkg::mem_addr_t waddr1,
    input logic                    wen0,
    input logic                    wen1,
    input logic                    brsel0,
    input logic                    brsel1,
    input logic                    brselen0,
    input logic                    brselen1,
    input logic                    ntt_finished,
    // reference model values
    input ntt_addr_pkg::mem_addr_t exp_raddr0,
    input ntt_addr_pkg::tw_addr_t  exp_raddr_tw,
    input ntt_addr_pkg::mem_addr_t exp_waddr0,
    input ntt_addr_pkg::mem_addr_t exp_waddr1,
    input logic                    exp_wen0,
    input logic                    exp_wen1,
    input logic                    exp_brsel0,
    input logic                    exp_brsel1,
    input logic                    exp_finished
);
    import ntt_addr_pkg::*;

    int errors       = 0;  // all mismatches of the run
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int wen0_seen    = 0;  // write cycles in the current test
    int wen1_seen    = 0;
    int finish_seen  = 0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s expected 0x%0h got 0x%0h", $time, name, want, got);
            errors++;
            test_errors++;
        end
    endtask

    // -------------------- sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (check_en) begin
            check_value("raddr0", raddr0, exp_raddr0);
            check_value("raddr_tw", raddr_tw, exp_raddr_tw);
            check_value("waddr0", waddr0, exp_waddr0);
            check_value("waddr1", waddr1, exp_waddr1);
            check_value("wen0", wen0, exp_wen0);
            check_value("wen1", wen1, exp_wen1);
            check_value("brsel0", brsel0, exp_brsel0);
            check_value("brsel1", brsel1, exp_brsel1);
            check_value("brselen0", brselen0, exp_wen0);  // enable follows wen
            check_value("brselen1", brselen1, exp_wen1);
            check_value("ntt_finished", ntt_finished, exp_finished);
            if (wen0 === 1'b1) wen0_seen++;
            if (wen1 === 1'b1) wen1_seen++;
            if (ntt_finished === 1'b1) finish_seen++;
        end
    end

    // -------------------- per test summary
    task automatic close_test(input string name);
        check_value("wen0 cycles", wen0_seen, ring_depth * (loop_limit + 1));
        check_value("wen1 cycles", wen1_seen, ring_depth * (loop_limit + 1));
        check_value("ntt_finished pulses", finish_seen, 1);  // exactly one per run
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
        wen0_seen   = 0;
        wen1_seen   = 0;
        finish_seen = 0;
    endtask

    task automatic print_totals();
        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    endtask

endmodule

// ==== dv/ntt_addr_gen_tb.sv ====
// testbench top for the NTT address generator, clock, reset, timeout, stimulus table, model
`timescale 1ns/1ps

module ntt_addr_gen_tb;
    import ntt_addr_pkg::*;

    localparam int pipe_delay  = 8;
    localparam int wait_cycles = 16;
    localparam int stage_len   = loop_limit + 1 + wait_cycles;
    localparam int num_rows    = 4;
    localparam int cycle_limit = num_rows * ring_depth * stage_len + 100;
    localparam int hist_len    = (pipe_delay + 2 > 5) ? pipe_delay + 2 : 5;

    typedef struct packed {
        mem_addr_t rd;     // read unit {half, word}
        tw_addr_t  tw;
        mem_addr_t we;     // write unit even side
        mem_addr_t wo;     // write unit odd side
        logic      wen;
        logic      brsel;
        logic      done;
    } unit_regs_t;

    logic      clk;
    logic      reset;
    logic      start;
    mem_addr_t raddr0, waddr0, waddr1;
    tw_addr_t  raddr_tw;
    logic      wen0, wen1, brsel0, brsel1, brselen0, brselen1, ntt_finished;
    mem_addr_t exp_raddr0, exp_waddr0, exp_waddr1;
    tw_addr_t  exp_raddr_tw;
    logic      exp_wen0, exp_wen1, exp_brsel0, exp_brsel1, exp_finished;
    logic      check_en;

    // -------------------- stimulus table
    int    row_gap  [num_rows] = '{3, 6, 12, 2};  // idle cycles before start
    bit    row_mid  [num_rows] = '{0, 1, 0, 1};   // extra start pulses mid-run
    string row_name [num_rows] = '{"first_run", "mid_start", "after_gap", "short_gap"};

    unit_regs_t hist [hist_len];  // hist[i] is i edges old
    logic       active = 1'b0;    // model sequencer busy
    int         pos    = 0;       // edges since accepted start
    int         cycles = 0;

    ntt_addr_gen #(.pipe_delay(pipe_delay), .wait_cycles(wait_cycles)) ntt_addr_gen_i (
        .clk(clk), .reset(reset), .start(start), .raddr0(raddr0), .raddr_tw(raddr_tw),
        .waddr0(waddr0), .waddr1(waddr1), .wen0(wen0), .wen1(wen1), .brsel0(brsel0),
        .brsel1(brsel1), .brselen0(brselen0), .brselen1(brselen1), .ntt_finished(ntt_finished)
    );

    ntt_addr_checker result_chk (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // upper word of a pair sits 2^k above the lower one
    function automatic bank_addr_t pair_word(input int loop, input int s, input bit upper);
        int k;
        int w;
        if (s >= bank_bits - 1) begin
            return bank_addr_t'(loop);  // late stages use the plain loop index
        end
        k = bank_bits - 2 - s;
        w = (loop / 2) + ((loop >> (k + 1)) << k);
        return bank_addr_t'(upper ? w + (1 << k) : w);
    endfunction

    // -------------------- reference model for one clock edge
    task automatic update_model(input logic start_in);
        unit_regs_t nx;
        int         s;
        int         ph;
        bit         run;
        bit         stage_step;
        bit         go;
        bit         last;
        logic [1:0] half;
        nx = hist[0];
        s = 0;
        ph = 0;
        run = 1'b0;
        stage_step = 1'b0;
        go = !active && start_in;  // start only counts when idle
        if (active) begin
            pos++;
            s          = (pos - 1) / stage_len;
            ph         = (pos - 1) % stage_len;  // loop index during run
            run        = (ph <= loop_limit);
            stage_step = (ph == stage_len - 1);
        end
        last = (s == ring_depth - 1);
        if (go) begin
            nx.rd = '0;
            nx.tw = '0;
            nx.we = {2'b01, bank_addr_t'(0)};
            nx.wo = {2'b01, bank_addr_t'(1 << (bank_bits - 1))};
        end else if (stage_step) begin
            nx.rd = {nx.rd[bank_bits+1], ~nx.rd[bank_bits], bank_addr_t'(0)};
            nx.tw = last ? tw_addr_t'(0) : tw_addr_t'(nx.tw + 1);
            half  = (s == ring_depth - 2) ? 2'b10 : {nx.we[bank_bits+1], ~nx.we[bank_bits]};
            nx.we = {half, bank_addr_t'(0)};
            nx.wo = {half, bank_addr_t'(0)};
        end else if (run) begin
            nx.rd[bank_bits-1:0] = pair_word(ph, s, ph % 2);
            nx.we[bank_bits-1:0] = pair_word(ph, s, 1'b0);
            nx.wo[bank_bits-1:0] = pair_word(ph, s, 1'b1);
            if (ph < loop_limit) begin
                if ((ph & (loop_limit >> s)) == (loop_limit >> s)) begin
                    nx.tw = tw_addr_t'(nx.tw + 1);
                end else if (ph % 2 == 0) begin
                    nx.tw = tw_addr_t'(nx.tw + ((1 << half_shift) >> s));
                end else begin
                    nx.tw = tw_addr_t'(nx.tw + 1 - ((1 << half_shift) >> s));
                end
            end
        end
        nx.wen   = run;
        nx.brsel = run && (ph % 2 == 1);
        nx.done  = stage_step && last;
        if (nx.done) active = 1'b0;
        if (go) begin
            active = 1'b1;
            pos    = 0;
        end
        for (int i = hist_len - 1; i > 0; i--) hist[i] = hist[i-1];
        hist[0] = nx;
    endtask

    // read side lags 1 edge and the write side pipe_delay plus the odd lag
    task automatic load_expected();
        exp_raddr0   = hist[1].rd;
        exp_raddr_tw = hist[1].tw;
        exp_waddr0   = hist[pipe_delay].we;
        exp_waddr1   = hist[pipe_delay+1].wo;
        exp_wen0     = hist[pipe_delay].wen;
        exp_wen1     = hist[pipe_delay+1].wen;
        exp_brsel0   = hist[pipe_delay].brsel;
        exp_brsel1   = hist[pipe_delay+1].brsel;
        exp_finished = hist[4].done;
    endtask

    task automatic advance_cycle();
        logic sampled_start;
        @(posedge clk);
        sampled_start = start;  // what the DUT saw at this edge
        #1;
        update_model(sampled_start);
        load_expected();
    endtask

    task automatic run_row(input int idx);
        int n;
        repeat (row_gap[idx] + ($urandom % 4)) advance_cycle();
        start = 1'b1;
        advance_cycle();
        start = 1'b0;
        n = 0;
        while (!ntt_finished) begin
            n++;
            start = row_mid[idx] && (n == 27 || n == 40);  // start while busy must be ignored
            advance_cycle();
        end
        start = 1'b0;
        repeat (3) advance_cycle();
        result_chk.close_test(row_name[idx]);
    endtask

    // -------------------- main sequence
    initial begin
        void'($urandom(2));
        reset    = 1'b1;
        start    = 1'b0;
        check_en = 1'b0;
        for (int i = 0; i < hist_len; i++) hist[i] = '0;
        load_expected();
        repeat (3) @(posedge clk);
        #1;
        reset    = 1'b0;
        check_en = 1'b1;  // idle outputs checked from here on
        for (int i = 0; i < num_rows; i++) run_row(i);
        check_en = 1'b0;
        result_chk.print_totals();
        if (result_chk.errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== hdl/delay_line.sv ====
// reset-clearing shift register of configurable depth and width
`timescale 1ns/1ps

module delay_line #(
    parameter int depth = 1,
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] d,
    output logic [width-1:0] q
);

    logic [width-1:0] taps [depth];  // taps[0] is the first register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= d;
            for (int i = 1; i < depth; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign q = taps[depth-1];

endmodule

// ==== hdl/ntt_addr_gen.sv ====
// NTT address generator top level, sequencer, address units and output alignment
`timescale 1ns/1ps

module ntt_addr_gen #(
    parameter int pipe_delay  = 8,   // butterfly mul + reduce + stage latency
    parameter int wait_cycles = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output ntt_addr_pkg::mem_addr_t raddr0,
    output ntt_addr_pkg::tw_addr_t  raddr_tw,
    output ntt_addr_pkg::mem_addr_t waddr0,
    output ntt_addr_pkg::mem_addr_t waddr1,
    output logic                    wen0,
    output logic                    wen1,
    output logic                    brsel0,
    output logic                    brsel1,
    output logic                    brselen0,
    output logic                    brselen1,
    output logic                    ntt_finished
);
    import ntt_addr_pkg::*;

    localparam int odd_delay = pipe_delay + 1;  // odd side lags one cycle

    ntt_step_if step ();

    mem_addr_t rd_addr;
    tw_addr_t  tw_addr;
    mem_addr_t wr_even;
    mem_addr_t wr_odd;
    logic      wr_en;
    logic      wr_brsel;
    logic      wr_brselen;
    logic      seq_done;

    // -------------------- schedule and address units
    ntt_sequencer #(.wait_cycles(wait_cycles)) u_seq (
        .clk(clk), .reset(reset), .start(start), .step(step.seq), .done(seq_done)
    );

    ntt_read_addr u_rd (.clk(clk), .reset(reset), .step(step.unit), .raddr(rd_addr));

    ntt_twiddle_addr u_tw (.clk(clk), .reset(reset), .step(step.unit), .tw_addr(tw_addr));

    ntt_write_addr u_wr (
        .clk(clk), .reset(reset), .step(step.unit),
        .waddr_even(wr_even), .waddr_odd(wr_odd),
        .wen(wr_en), .brsel(wr_brsel), .brselen(wr_brselen)
    );

    // -------------------- read side, one output register
    delay_line #(.depth(1), .width($bits(mem_addr_t))) u_dl_raddr (
        .clk(clk), .reset(reset), .d(rd_addr), .q(raddr0)
    );
    delay_line #(.depth(1), .width($bits(tw_addr_t))) u_dl_tw (
        .clk(clk), .reset(reset), .d(tw_addr), .q(raddr_tw)
    );

    // -------------------- write side, butterfly latency
    delay_line #(.depth(pipe_delay), .width($bits(mem_addr_t))) u_dl_waddr0 (
        .clk(clk), .reset(reset), .d(wr_even), .q(waddr0)
    );
    delay_line #(.depth(odd_delay), .width($bits(mem_addr_t))) u_dl_waddr1 (
        .clk(clk), .reset(reset), .d(wr_odd), .q(waddr1)
    );
    delay_line #(.depth(pipe_delay), .width(1)) u_dl_wen0 (
        .clk(clk), .reset(reset), .d(wr_en), .q(wen0)
    );
    delay_line #(.depth(odd_delay), .width(1)) u_dl_wen1 (
        .clk(clk), .reset(reset), .d(wr_en), .q(wen1)
    );
    delay_line #(.depth(pipe_delay), .width(1)) u_dl_brsel0 (
        .clk(clk), .reset(reset), .d(wr_brsel), .q(brsel0)
    );
    delay_line #(.depth(odd_delay), .width(1)) u_dl_brsel1 (
        .clk(clk), .reset(reset), .d(wr_brsel), .q(brsel1)
    );
    delay_line #(.depth(pipe_delay), .width(1)) u_dl_brselen0 (
        .clk(clk), .reset(reset), .d(wr_brselen), .q(brselen0)
    );
    delay_line #(.depth(odd_delay), .width(1)) u_dl_brselen1 (
        .clk(clk), .reset(reset), .d(wr_brselen), .q(brselen1)
    );

    // finish flag trails the sequencer done by 4
    delay_line #(.depth(4), .width(1)) u_dl_finish (
        .clk(clk), .reset(reset), .d(seq_done), .q(ntt_finished)
    );

endmodule

// ==== hdl/ntt_addr_pkg.sv ====
// ring geometry constants, address and counter types, sequencer state enum, butterfly address rule
package ntt_addr_pkg;

    // -------------------- ring geometry
    localparam int ring_depth = 5;                     // log2 N, N = 32
    localparam int pe_depth   = 1;                     // log2 of butterfly unit count
    localparam int bank_bits  = ring_depth - pe_depth; // word bits inside one bank
    localparam int loop_limit = ((1 << ring_depth) >> (pe_depth + 1)) - 1;
    localparam int half_shift = bank_bits - 2;         // twiddle jump base

    // -------------------- types
    typedef logic [bank_bits-1:0] bank_addr_t;  // word inside a bank
    typedef logic [bank_bits:0]   loop_t;       // loop counter
    typedef logic [bank_bits+1:0] mem_addr_t;   // {bank half, word}
    typedef logic [bank_bits+2:0] tw_addr_t;    // twiddle rom address
    typedef logic [4:0]           stage_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_wait
    } seq_state_t;

    // lower word of a butterfly pair, plain loop once the span drops below one word
    function automatic bank_addr_t bfly_base(loop_t loop, stage_t stage);
        int    k;
        loop_t sum;
        if (stage < stage_t'(bank_bits - 1)) begin
            k   = bank_bits - 2 - int'(stage);
            sum = (loop >> 1) + ((loop >> (k + 1)) << k);
        end else begin
            sum = loop;
        end
        return bank_addr_t'(sum);
    endfunction

    // distance between the two words of a pair, 2^k in early stages
    function automatic bank_addr_t bfly_span(stage_t stage);
        if (stage < stage_t'(bank_bits - 1)) begin
            return bank_addr_t'(1) << (bank_bits - 2 - int'(stage));
        end
        return '0;
    endfunction

endpackage

// ==== hdl/ntt_read_addr.sv ====
// read address unit, butterfly word order plus read bank-half toggle
`timescale 1ns/1ps

module ntt_read_addr (
    input  logic                    clk,
    input  logic                    reset,
    ntt_step_if.unit                step,
    output ntt_addr_pkg::mem_addr_t raddr
);
    import ntt_addr_pkg::*;

    bank_addr_t word;     // word inside the bank
    logic [1:0] half;     // ping-pong bank half
    bank_addr_t base;
    bank_addr_t span;

    // pair base and spacing for the current stage
    assign base = bfly_base(step.loop, step.stage);
    assign span = bfly_span(step.stage);

    assign raddr = {half, word};

    // -------------------- word address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (step.go || step.stage_step) begin
            word <= '0;
        end else if (step.run) begin
            // odd loops take the upper word of the pair
            word <= step.loop[0] ? base + span : base;
        end
    end

    // -------------------- bank half
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            half <= 2'b00;
        end else if (step.go) begin
            half <= 2'b00;
        end else if (step.stage_step) begin
            half <= {half[1], ~half[0]};  // swap read/write halves each stage
        end
    end

endmodule

// ==== hdl/ntt_sequencer.sv ====
// idle/run/wait FSM with stage, loop and wait counters and the done pulse
`timescale 1ns/1ps

module ntt_sequencer #(
    parameter int wait_cycles = 16
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    ntt_step_if.seq step,
    output logic    done
);
    import ntt_addr_pkg::*;

    localparam int wait_w = (wait_cycles > 1) ? $clog2(wait_cycles) : 1;

    seq_state_t        state;
    stage_t            stage;
    loop_t             loop;
    logic [wait_w-1:0] wait_cnt;
    logic              wait_end;   // last cycle of the wait phase

    assign wait_end = (state == seq_wait) && (wait_cnt == wait_w'(wait_cycles - 1));

    // -------------------- schedule flags
    assign step.run          = (state == seq_run);
    assign step.loop         = loop;
    assign step.stage        = stage;
    assign step.stage_step   = wait_end;
    assign step.last_stage   = (stage == stage_t'(ring_depth - 1));
    assign step.penult_stage = (stage == stage_t'(ring_depth - 2));
    assign step.go           = (state == seq_idle) && start; // start ignored outside idle

    // -------------------- state machine
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle: begin
                    if (start) begin
                        state <= seq_run;
                    end
                end
                seq_run: begin
                    if (loop == loop_t'(loop_limit)) begin
                        state <= seq_wait;  // last butterfly pair issued
                    end
                end
                seq_wait: begin
                    if (wait_end) begin
                        state <= step.last_stage ? seq_idle : seq_run;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // -------------------- stage / loop / wait counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage    <= '0;
            loop     <= '0;
            wait_cnt <= '0;
            done     <= 1'b0;
        end else begin
            if (step.go) begin
                stage <= '0;
                loop  <= '0;
            end else if (wait_end) begin
                loop  <= '0;
                stage <= step.last_stage ? stage_t'(0) : stage + 1'b1;
            end else if ((state == seq_run) && (loop != loop_t'(loop_limit))) begin
                loop <= loop + 1'b1;
            end
            wait_cnt <= ((state == seq_wait) && !wait_end) ? wait_cnt + 1'b1 : '0;
            done     <= wait_end && step.last_stage; // one cycle after leaving last wait
        end
    end

endmodule

// ==== hdl/ntt_step_if.sv ====
// interface with the per-cycle schedule from the sequencer to the address units
`timescale 1ns/1ps

interface ntt_step_if;
    import ntt_addr_pkg::*;

    logic   run;          // high in every run cycle
    loop_t  loop;         // valid while run
    stage_t stage;
    logic   stage_step;   // last wait cycle of a stage
    logic   last_stage;   // stage == ring_depth-1
    logic   penult_stage; // stage == ring_depth-2
    logic   go;           // start accepted in idle

    modport seq (
        output run, loop, stage,
        output stage_step, last_stage, penult_stage,
        output go
    );

    modport unit (
        input run, loop, stage,
        input stage_step, last_stage, penult_stage,
        input go
    );

endinterface

// ==== hdl/ntt_twiddle_addr.sv ====
// twiddle factor address counter
`timescale 1ns/1ps

module ntt_twiddle_addr (
    input  logic                   clk,
    input  logic                   reset,
    ntt_step_if.unit               step,
    output ntt_addr_pkg::tw_addr_t tw_addr
);
    import ntt_addr_pkg::*;

    loop_t    mask;   // loop bits that close a twiddle group
    tw_addr_t jump;   // stride between paired twiddles
    logic     step_en;

    assign mask    = loop_t'(loop_limit) >> step.stage;
    assign jump    = tw_addr_t'(1 << half_shift) >> step.stage;
    assign step_en = step.run && (step.loop != loop_t'(loop_limit));

    // -------------------- counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tw_addr <= '0;
        end else if (step.go) begin
            tw_addr <= '0;
        end else if (step_en) begin
            if ((step.loop & mask) == mask) begin
                tw_addr <= tw_addr + 1'b1;         // group closed
            end else if (!step.loop[0]) begin
                tw_addr <= tw_addr + jump;          // even loop, jump ahead
            end else begin
                tw_addr <= tw_addr + 1'b1 - jump;   // odd loop, come back
            end
        end else if (step.stage_step) begin
            // next stage starts one above, wrap after the last one
            tw_addr <= step.last_stage ? tw_addr_t'(0) : tw_addr + 1'b1;
        end
    end

endmodule

// ==== hdl/ntt_write_addr.sv ====
// even/odd write addresses, write bank half, write enable and bank select
`timescale 1ns/1ps

module ntt_write_addr (
    input  logic                    clk,
    input  logic                    reset,
    ntt_step_if.unit                step,
    output ntt_addr_pkg::mem_addr_t waddr_even,
    output ntt_addr_pkg::mem_addr_t waddr_odd,
    output logic                    wen,
    output logic                    brsel,
    output logic                    brselen
);
    import ntt_addr_pkg::*;

    bank_addr_t word_even;
    bank_addr_t word_odd;
    logic [1:0] half;       // write bank half
    bank_addr_t base;
    bank_addr_t span;

    assign base = bfly_base(step.loop, step.stage);
    assign span = bfly_span(step.stage);

    assign waddr_even = {half, word_even};
    assign waddr_odd  = {half, word_odd};

    // -------------------- pair addresses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word_even <= '0;
            word_odd  <= '0;
        end else if (step.go) begin
            word_even <= '0;
            word_odd  <= bank_addr_t'(1 << (bank_bits - 1)); // upper half of the bank
        end else if (step.stage_step) begin
            word_even <= '0;
            word_odd  <= '0;
        end else if (step.run) begin
            word_even <= base;
            word_odd  <= base + span;  // same as even in late stages
        end
    end

    // -------------------- bank half
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            half <= 2'b00;
        end else if (step.go) begin
            half <= 2'b01;  // first stage writes the opposite half
        end else if (step.stage_step) begin
            if (step.penult_stage) begin
                half <= 2'b10;  // final stage lands in the output half
            end else begin
                half <= {half[1], ~half[0]};
            end
        end
    end

    // -------------------- enables and bank select
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wen     <= 1'b0;
            brsel   <= 1'b0;
            brselen <= 1'b0;
        end else begin
            wen     <= step.run;
            brselen <= step.run;
            brsel   <= step.run && step.loop[0];  // alternate even/odd bram
        end
    end

endmodule

// ==== list.f ====
hdl/ntt_addr_pkg.sv
hdl/ntt_step_if.sv
hdl/delay_line.sv
hdl/ntt_sequencer.sv
hdl/ntt_read_addr.sv
hdl/ntt_twiddle_addr.sv
hdl/ntt_write_addr.sv
hdl/ntt_addr_gen.sv
dv/ntt_addr_checker.sv
dv/ntt_addr_gen_tb.sv
